/* vlog.f */
verilog/isaPkg.sv
verilog/hazardPkg.sv
verilog/regFile.sv
verilog/fetchDecode.sv
verilog/executeStage.sv
verilog/memWriteback.sv
verilog/hazardUnit.sv
verilog/cpuCore.sv
tests/cpuCoreTb.sv

/* run.sh */
#!/bin/sh
# Build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module cpuCoreTb -o cpuCoreSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -q "all tests passed" sim.log; then
	exit 0
fi
exit 1

/* tests/cpuCoreTb.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuCoreTb;
	localparam int loopIdx = 28; // Self-loop branch

	logic clk;
	logic rst;
	logic iReq;
	logic [31:0] iAddr;
	logic [31:0] iData;
	logic iDataOk;
	logic dReq;
	logic dWr;
	logic [31:0] dAddr;
	logic [31:0] dWdata;
	logic [31:0] dRdata;
	logic dDataOk;
	logic wbValid;
	logic [4:0] wbDest;
	logic [31:0] wbData;

	logic [31:0] imem [0:63];
	logic [31:0] dmem [0:63];
	logic [31:0] modelMem [0:63];
	logic [31:0] modelRegs [0:31];
	logic [4:0] expDest [$];
	logic [31:0] expData [$];
	int expTotal;
	int retired;
	int iWait;
	int dWait;

	cpuCore #(.resetPc(32'h0)) u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic reportFail(string msg);
		$display("%s", msg);
		$display("tests failed");
		$fatal(1);
	endtask

	function automatic logic [31:0] encodeR(int rs, int rt, int rd, logic [5:0] fn);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic logic [31:0] encodeI(logic [5:0] op, int rs, int rt, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	task automatic loadProgram();
		for (int i = 0; i < 64; i++) begin
			imem[i] = 32'h0; // Nop
			dmem[i] = {16'hda7a, 8'h00, i[5:0], 2'b00} ^ (i * 32'h0101_0000);
			modelMem[i] = dmem[i];
		end
		imem[0] = encodeI(6'h09, 0, 1, 5);
		imem[1] = encodeI(6'h09, 0, 2, -3);
		imem[2] = encodeR(1, 2, 3, 6'h21);
		imem[3] = encodeR(3, 1, 4, 6'h23);
		imem[4] = encodeR(4, 1, 5, 6'h24);
		imem[5] = encodeR(5, 2, 6, 6'h25);
		imem[6] = encodeR(2, 1, 7, 6'h2a);
		imem[7] = encodeI(6'h09, 1, 0, 9); // Write to r0 is dropped
		imem[8] = encodeR(0, 7, 8, 6'h21);
		imem[9] = encodeI(6'h2b, 0, 3, 16);
		imem[10] = encodeI(6'h2b, 0, 6, 20);
		imem[11] = encodeI(6'h23, 0, 9, 16);
		imem[12] = encodeR(9, 1, 10, 6'h21); // Load-use
		imem[13] = encodeI(6'h23, 0, 11, 20);
		imem[14] = encodeI(6'h04, 11, 6, 2); // Taken behind a load
		imem[15] = encodeI(6'h09, 0, 12, 1);
		imem[16] = encodeI(6'h09, 0, 13, 2);
		imem[17] = encodeI(6'h09, 0, 14, 3);
		imem[18] = encodeI(6'h05, 14, 0, 2); // Taken behind an ALU op
		imem[19] = encodeR(14, 14, 15, 6'h21);
		imem[20] = encodeI(6'h09, 0, 16, 7);
		imem[21] = encodeI(6'h04, 14, 1, 2);
		imem[22] = encodeI(6'h09, 0, 17, 5);
		imem[23] = encodeI(6'h05, 17, 1, 5); // Not taken behind an ALU op
		imem[24] = encodeI(6'h2b, 0, 17, 24);
		imem[25] = encodeI(6'h23, 0, 18, 24);
		imem[26] = encodeI(6'h05, 18, 17, 3);
		imem[27] = encodeR(18, 3, 19, 6'h25);
		imem[loopIdx] = encodeI(6'h04, 0, 0, -1);
	endtask

	task automatic recordWrite(logic [4:0] dest, logic [31:0] value);
		if (dest != 5'd0) begin
			modelRegs[dest] = value;
			expDest.push_back(dest);
			expData.push_back(value);
		end
	endtask

	// Sequential MIPS model with one delay slot
	task automatic runModel();
		logic [31:0] pc;
		logic [31:0] npc;
		logic [31:0] nextNpc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] sext;
		logic [31:0] addr;
		int steps;
		for (int i = 0; i < 32; i++)
			modelRegs[i] = 32'h0;
		pc = 32'h0;
		npc = 32'h4;
		steps = 0;
		while (pc != loopIdx * 4 && steps < 500) begin
			ins = imem[pc[7:2]];
			a = modelRegs[ins[25:21]];
			b = modelRegs[ins[20:16]];
			sext = {{16{ins[15]}}, ins[15:0]};
			addr = a + sext;
			nextNpc = npc + 32'd4;
			case (ins[31:26])
				6'h00: case (ins[5:0])
					6'h21: recordWrite(ins[15:11], a + b);
					6'h23: recordWrite(ins[15:11], a - b);
					6'h24: recordWrite(ins[15:11], a & b);
					6'h25: recordWrite(ins[15:11], a | b);
					6'h2a: recordWrite(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
					default: ;
				endcase
				6'h09: recordWrite(ins[20:16], a + sext);
				6'h23: recordWrite(ins[20:16], modelMem[addr[7:2]]);
				6'h2b: modelMem[addr[7:2]] = b;
				6'h04: if (a == b) nextNpc = pc + 32'd4 + {sext[29:0], 2'b00};
				6'h05: if (a != b) nextNpc = pc + 32'd4 + {sext[29:0], 2'b00};
				default: ;
			endcase
			pc = npc;
			npc = nextNpc;
			steps++;
		end
		expTotal = expDest.size();
	endtask

	// Instruction memory with random wait states
	always @(posedge clk) begin
		#2;
		iDataOk = 1'b0;
		if (rst && iReq) begin
			if (iWait == 0) begin
				iDataOk = 1'b1;
				iData = imem[iAddr[7:2]];
				iWait = $urandom % 3;
			end else begin
				iWait--;
			end
		end
	end

	// Data memory with zero or more wait states
	always @(posedge clk) begin
		#2;
		dDataOk = 1'b0;
		if (rst && dReq) begin
			if (dAddr[31:8] != 24'h0)
				reportFail("Data access outside the data memory");
			else if (dWait == 0) begin
				dDataOk = 1'b1;
				dRdata = dmem[dAddr[7:2]];
				if (dWr)
					dmem[dAddr[7:2]] = dWdata;
				dWait = $urandom % 4;
			end else begin
				dWait--;
			end
		end
	end

	// Retire trace against the model
	always @(negedge clk) begin
		if (rst && wbValid) begin
			if (expDest.size() == 0)
				reportFail("Register write seen after the last expected write");
			else begin
				assert (wbDest == expDest[0] && wbData == expData[0])
				else reportFail($sformatf("Mismatch at %0t: r%0d = %h, expected r%0d = %h",
					$time, wbDest, wbData, expDest[0], expData[0]));
				void'(expDest.pop_front());
				void'(expData.pop_front());
				retired++;
			end
		end
	end

	initial begin
		int cycles;
		iWait = $urandom(32'h4bc8_7d0f) % 3;
		rst = 1'b0;
		iData = 32'h0;
		iDataOk = 1'b0;
		dRdata = 32'h0;
		dDataOk = 1'b0;
		retired = 0;
		loadProgram();
		runModel();
		dWait = $urandom % 4;
		repeat (3) @(posedge clk);
		#2 rst = 1'b1;

		cycles = 0;
		while (retired < expTotal && cycles < 2000) begin
			@(posedge clk);
			cycles++;
		end
		if (retired < expTotal)
			reportFail($sformatf("Timeout: only %0d of %0d writes retired", retired, expTotal));

		cycles = 0;
		while (cycles < 40) begin // Self-loop must stay quiet
			@(posedge clk);
			cycles++;
		end

		for (int i = 0; i < 64; i++) begin
			assert (dmem[i] == modelMem[i])
			else reportFail($sformatf("Mismatch at %0t: dmem[%0d] = %h, expected %h",
				$time, i, dmem[i], modelMem[i]));
		end
		$display("all tests passed");
		$finish;
	end
endmodule

`default_nettype wire

/* verilog/cpuCore.sv */
`timescale 1ns/100ps
`default_nettype none

module cpuCore #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input wire clk,
	input wire rst,
	output logic iReq,
	output isaPkg::word iAddr,
	input wire isaPkg::word iData,
	input wire iDataOk,
	output logic dReq,
	output logic dWr,
	output isaPkg::word dAddr,
	output isaPkg::word dWdata,
	input wire isaPkg::word dRdata,
	input wire dDataOk,
	output logic wbValid,
	output isaPkg::regIdx wbDest,
	output isaPkg::word wbData
);
	import isaPkg::*;
	import hazardPkg::*;

	logic fetchDone, frontStall, freeze, brFwdA, brFwdB, isBranch;
	logic idValid, idRegWr, idMemRd, idMemWr, idUseImm;
	regIdx idRs, idRt, idDest;
	word idRsVal, idRtVal, idImm;
	aluOp idAluOp;

	fwdSel fwdA, fwdB;
	regIdx exRs, exRt, exDest;
	logic exRegWr, exMemRd, exMemWr;
	word exResult, exStoreData;

	regIdx memDest;
	logic memRegWr, memMemRd, memAccess;
	word memResult;

	fetchDecode #(.resetPc(resetPc)) uFetchDecode (.*);

	executeStage uExecuteStage (.*);

	memWriteback uMemWriteback (.*);

	hazardUnit uHazardUnit (.*);
endmodule

`default_nettype wire

/* verilog/hazardUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazardUnit (
	input wire clk,
	input wire rst,
	input wire isaPkg::regIdx idRs,
	input wire isaPkg::regIdx idRt,
	input wire isBranch,
	input wire fetchDone,
	input wire isaPkg::regIdx exRs,
	input wire isaPkg::regIdx exRt,
	input wire isaPkg::regIdx exDest,
	input wire exRegWr,
	input wire exMemRd,
	input wire isaPkg::regIdx memDest,
	input wire memRegWr,
	input wire memMemRd,
	input wire memAccess,
	input wire dDataOk,
	input wire isaPkg::regIdx wbDest,
	input wire wbValid,
	output hazardPkg::fwdSel fwdA,
	output hazardPkg::fwdSel fwdB,
	output logic brFwdA,
	output logic brFwdB,
	output logic frontStall,
	output logic freeze
);
	import isaPkg::*;
	import hazardPkg::*;

	typedef enum logic {accFree, accBusy} accState;

	accState state;
	accState stateNext;
	logic memAluWr;
	logic loadUse;
	logic brWaitEx;
	logic brWaitMem;

	function automatic logic hitsId(regIdx dest);
		return dest != '0 && (dest == idRs || dest == idRt);
	endfunction

	assign memAluWr = memRegWr && !memMemRd && memDest != '0;

	// MEM before WB, register 0 excluded
	always_comb begin
		fwdA = fwdNone;
		if (memAluWr && memDest == exRs)
			fwdA = fwdMem;
		else if (wbValid && wbDest == exRs)
			fwdA = fwdWb;
		fwdB = fwdNone;
		if (memAluWr && memDest == exRt)
			fwdB = fwdMem;
		else if (wbValid && wbDest == exRt)
			fwdB = fwdWb;
	end

	assign brFwdA = isBranch && memAluWr && memDest == idRs;
	assign brFwdB = isBranch && memAluWr && memDest == idRt;

	assign loadUse = exMemRd && hitsId(exDest);
	assign brWaitEx = isBranch && exRegWr && hitsId(exDest);
	assign brWaitMem = isBranch && memRegWr && memMemRd && hitsId(memDest);
	assign frontStall = loadUse || brWaitEx || brWaitMem || !fetchDone;

	always_ff @(posedge clk) begin
		if (!rst)
			state <= accFree;
		else
			state <= stateNext;
	end

	always_comb begin
		stateNext = state;
		case (state)
			accFree: if (memAccess && !dDataOk) stateNext = accBusy;
			accBusy: if (dDataOk) stateNext = accFree;
			default: stateNext = accFree;
		endcase
	end

	// Frozen from the first cycle of an access, released in its dDataOk cycle
	assign freeze = (state == accBusy) ? !dDataOk : memAccess && !dDataOk;

	assert property (@(posedge clk) disable iff (!rst) state == accBusy |-> memAccess)
		else $error("hazardUnit: access vanished while outstanding");
endmodule

`default_nettype wire

/* verilog/memWriteback.sv */
`timescale 1ns/100ps
`default_nettype none

module memWriteback (
	input wire clk,
	input wire rst,
	input wire freeze,
	input wire isaPkg::regIdx exDest,
	input wire exRegWr,
	input wire exMemRd,
	input wire exMemWr,
	input wire isaPkg::word exResult,
	input wire isaPkg::word exStoreData,
	output logic dReq,
	output logic dWr,
	output isaPkg::word dAddr,
	output isaPkg::word dWdata,
	input wire isaPkg::word dRdata,
	input wire dDataOk,
	output isaPkg::regIdx memDest,
	output logic memRegWr,
	output logic memMemRd,
	output logic memAccess,
	output isaPkg::word memResult,
	output logic wbValid,
	output isaPkg::regIdx wbDest,
	output isaPkg::word wbData
);
	import isaPkg::*;

	logic memMemWr;
	logic wbRegWr;
	word storeData;

	always_ff @(posedge clk) begin
		if (!rst) begin
			memRegWr <= 1'b0;
			memMemRd <= 1'b0;
			memMemWr <= 1'b0;
			wbRegWr <= 1'b0;
		end else if (!freeze) begin
			memRegWr <= exRegWr;
			memMemRd <= exMemRd;
			memMemWr <= exMemWr;
			wbRegWr <= memRegWr && memDest != '0; // Writes to r0 vanish here
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			memDest <= exDest;
			memResult <= exResult;
			storeData <= exStoreData;
			wbDest <= memDest;
			wbData <= memMemRd ? dRdata : memResult; // Unfrozen load means dDataOk
		end
	end

	assign memAccess = memMemRd || memMemWr;
	assign dReq = memAccess;
	assign dWr = memMemWr;
	assign dAddr = memResult;
	assign dWdata = storeData;

	// Held while frozen, shown once
	assign wbValid = wbRegWr && !freeze;

	assert property (@(posedge clk) disable iff (!rst)
		dReq && !dDataOk |=> dReq && $stable(dWr) && $stable(dAddr) && $stable(dWdata))
		else $error("memWriteback: data request changed before dDataOk");
endmodule

`default_nettype wire

/* verilog/executeStage.sv */
`timescale 1ns/100ps
`default_nettype none

module executeStage (
	input wire clk,
	input wire rst,
	input wire freeze,
	input wire frontStall,
	input wire idValid,
	input wire isaPkg::regIdx idRs,
	input wire isaPkg::regIdx idRt,
	input wire isaPkg::regIdx idDest,
	input wire isaPkg::word idRsVal,
	input wire isaPkg::word idRtVal,
	input wire isaPkg::word idImm,
	input wire isaPkg::aluOp idAluOp,
	input wire idRegWr,
	input wire idMemRd,
	input wire idMemWr,
	input wire idUseImm,
	input wire hazardPkg::fwdSel fwdA,
	input wire hazardPkg::fwdSel fwdB,
	input wire isaPkg::word memResult,
	input wire isaPkg::word wbData,
	output isaPkg::regIdx exRs,
	output isaPkg::regIdx exRt,
	output isaPkg::regIdx exDest,
	output logic exRegWr,
	output logic exMemRd,
	output logic exMemWr,
	output isaPkg::word exResult,
	output isaPkg::word exStoreData
);
	import isaPkg::*;
	import hazardPkg::*;

	word rsVal;
	word rtVal;
	word imm;
	aluOp op;
	logic useImm;
	word opA;
	word opB;

	always_ff @(posedge clk) begin
		if (!rst) begin
			exRegWr <= 1'b0;
			exMemRd <= 1'b0;
			exMemWr <= 1'b0;
		end else if (!freeze) begin
			exRegWr <= idValid && idRegWr && !frontStall; // Bubble on front stall
			exMemRd <= idValid && idMemRd && !frontStall;
			exMemWr <= idValid && idMemWr && !frontStall;
		end
	end

	always_ff @(posedge clk) begin
		if (!freeze) begin
			exRs <= idRs;
			exRt <= idRt;
			exDest <= idDest;
			rsVal <= idRsVal;
			rtVal <= idRtVal;
			imm <= idImm;
			op <= idAluOp;
			useImm <= idUseImm;
		end
	end

	always_comb begin
		case (fwdA)
			fwdMem: opA = memResult;
			fwdWb: opA = wbData;
			default: opA = rsVal;
		endcase
		case (fwdB)
			fwdMem: exStoreData = memResult;
			fwdWb: exStoreData = wbData;
			default: exStoreData = rtVal;
		endcase
		opB = useImm ? imm : exStoreData;
	end

	always_comb begin
		case (op)
			aluSub: exResult = opA - opB;
			aluAnd: exResult = opA & opB;
			aluOr: exResult = opA | opB;
			aluSlt: exResult = {31'b0, $signed(opA) < $signed(opB)};
			default: exResult = opA + opB; // Also load/store address
		endcase
	end
endmodule

`default_nettype wire

/* verilog/fetchDecode.sv */
`timescale 1ns/100ps
`default_nettype none

module fetchDecode #(
	parameter logic [31:0] resetPc = 32'h0
) (
	input wire clk,
	input wire rst,
	output logic iReq,
	output isaPkg::word iAddr,
	input wire isaPkg::word iData,
	input wire iDataOk,
	output logic fetchDone,
	input wire frontStall,
	input wire freeze,
	input wire brFwdA,
	input wire brFwdB,
	input wire isaPkg::word memResult,
	input wire wbValid,
	input wire isaPkg::regIdx wbDest,
	input wire isaPkg::word wbData,
	output isaPkg::regIdx idRs,
	output isaPkg::regIdx idRt,
	output logic isBranch,
	output logic idValid,
	output isaPkg::word idRsVal,
	output isaPkg::word idRtVal,
	output isaPkg::word idImm,
	output isaPkg::regIdx idDest,
	output isaPkg::aluOp idAluOp,
	output logic idRegWr,
	output logic idMemRd,
	output logic idMemWr,
	output logic idUseImm
);
	import isaPkg::*;

	word pc;
	word ifPcNext; // Address of the delay slot
	instrWord ifInstr;
	logic ifValid;
	logic fetchOn;
	logic accept;
	logic brOp;
	logic taken;
	word brA;
	word brB;
	word brTarget;

	assign iReq = fetchOn;
	assign iAddr = pc;
	assign fetchDone = iReq && iDataOk;
	assign accept = fetchDone && !frontStall && !freeze; // Else refetched

	always_ff @(posedge clk) begin
		if (!rst) begin
			fetchOn <= 1'b0;
			pc <= resetPc;
			ifValid <= 1'b0;
		end else begin
			fetchOn <= 1'b1;
			if (accept) begin
				pc <= taken ? brTarget : pc + 32'd4;
				ifValid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			ifInstr <= iData;
			ifPcNext <= pc + 32'd4;
		end
	end

	regFile uRegFile (
		.clk(clk),
		.raddrA(idRs),
		.raddrB(idRt),
		.rdataA(idRsVal),
		.rdataB(idRtVal),
		.we(wbValid),
		.waddr(wbDest),
		.wdata(wbData)
	);

	assign idValid = ifValid;
	assign idRs = ifValid ? ifInstr.rType.rs : '0;
	assign idRt = ifValid ? ifInstr.rType.rt : '0;
	assign idImm = {{16{ifInstr.iType.imm[15]}}, ifInstr.iType.imm};

	always_comb begin
		idAluOp = aluAdd;
		idRegWr = 1'b0;
		idMemRd = 1'b0;
		idMemWr = 1'b0;
		idUseImm = 1'b1;
		idDest = ifInstr.iType.rt;
		brOp = 1'b0;
		case (ifInstr.iType.opcode)
			opSpecial: begin
				idUseImm = 1'b0;
				idDest = ifInstr.rType.rd;
				idRegWr = 1'b1;
				case (ifInstr.rType.funct)
					fnAddu: idAluOp = aluAdd;
					fnSubu: idAluOp = aluSub;
					fnAnd: idAluOp = aluAnd;
					fnOr: idAluOp = aluOr;
					fnSlt: idAluOp = aluSlt;
					default: idRegWr = 1'b0; // Unsupported funct does nothing
				endcase
			end
			opAddiu: idRegWr = 1'b1;
			opLw: begin
				idRegWr = 1'b1;
				idMemRd = 1'b1;
			end
			opSw: idMemWr = 1'b1;
			opBeq, opBne: brOp = 1'b1;
			default: ;
		endcase
	end

	// Branch resolved here while the delay slot is fetched
	assign isBranch = ifValid && brOp;
	assign brA = brFwdA ? memResult : idRsVal;
	assign brB = brFwdB ? memResult : idRtVal;
	assign taken = isBranch && ((brA == brB) ^ (ifInstr.iType.opcode == opBne));
	assign brTarget = ifPcNext + {idImm[29:0], 2'b00};
endmodule

`default_nettype wire

/* verilog/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

module regFile (
	input wire clk,
	input wire isaPkg::regIdx raddrA,
	input wire isaPkg::regIdx raddrB,
	output isaPkg::word rdataA,
	output isaPkg::word rdataB,
	input wire we,
	input wire isaPkg::regIdx waddr,
	input wire isaPkg::word wdata
);
	import isaPkg::*;

	word regs [1:31];

	function automatic word readPort(regIdx addr);
		if (addr == '0)
			return '0;
		if (we && addr == waddr)
			return wdata; // Same-cycle write seen by decode
		return regs[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (we && waddr != '0)
			regs[waddr] <= wdata;
	end

	always_comb begin
		rdataA = readPort(raddrA);
		rdataB = readPort(raddrB);
	end

	// Writeback filters out register 0 before the strobe
	assert property (@(posedge clk) we |-> waddr != '0)
		else $error("regFile: write strobe with register 0");
endmodule

`default_nettype wire

/* verilog/hazardPkg.sv */
`default_nettype none

package hazardPkg;
	// Source of an execute operand
	typedef enum logic [1:0] {
		fwdNone = 2'b00, // Register file
		fwdMem = 2'b01, // ALU result sitting in EX/MEM
		fwdWb = 2'b10 // Value being written back
	} fwdSel;
endpackage

`default_nettype wire

/* verilog/isaPkg.sv */
`default_nettype none

package isaPkg;
	typedef logic [4:0] regIdx;
	typedef logic [31:0] word;

	typedef struct packed {
		logic [5:0] opcode;
		regIdx rs;
		regIdx rt;
		regIdx rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rTypeFields;

	typedef struct packed {
		logic [5:0] opcode;
		regIdx rs;
		regIdx rt;
		logic [15:0] imm;
	} iTypeFields;

	typedef union packed {
		rTypeFields rType;
		iTypeFields iType;
	} instrWord;

	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;

	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt} aluOp;
endpackage

`default_nettype wire
